/* tb/prefetch_trace.txt */
# name  base_addr(hex)  length(decimal words)  consumer stall percent(decimal)
# One job per line, run in order; consecutive lines start back to back
basic_stream   100  20   0
heavy_stall    3c0  48  70
single_word    7ff   1   0
zero_length    200   0   0
b2b_first      010  16  25
b2b_second     9a0  24  25
long_stall     c00  64  50

/* prefetch_top.f */
+incdir+include
logic/prefetch_pkg.sv
logic/prefetch_wr_if.sv
logic/fifo_ctrl_fsm.sv
logic/fifo_small_prefetch.sv
logic/prefetch_ctrl.sv
logic/resp_align.sv
logic/prefetch_top.sv
tb/prefetch_checker.sv
tb/prefetch_scoreboard.sv
tb/tb_prefetch_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the prefetcher testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_prefetch_top -f prefetch_top.f

# Assertion failures are counted by the testbench, so the run must not stop at the first one
out=$(./obj_dir/Vtb_prefetch_top +verilator+error+limit+1000 || true)
echo "$out"
echo "$out" | grep -qx "Testbench passed"

/* tb/tb_prefetch_top.sv */
// Reads tb/prefetch_trace.txt relative to the project root; jobs run one at a time in trace order
`default_nettype none
`timescale 1ns/100ps

`include "prefetch_defines.svh"

module tb_prefetch_top;

    localparam int LAT = `PF_MEM_LATENCY;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                start;
    prefetch_pkg::addr_t base_addr;
    prefetch_pkg::len_t  length;
    logic                mem_rd_en;
    prefetch_pkg::addr_t mem_addr;
    prefetch_pkg::data_t mem_rd_data = '0;
    logic                out_valid;
    prefetch_pkg::data_t out_data;
    logic                out_ready;
    logic                busy;
    logic                done;
    logic                oflow;

    // Jobs from the trace, one entry per line
    string               names [$];
    prefetch_pkg::addr_t bases [$];
    prefetch_pkg::len_t  lengths [$];
    int                  stalls [$];

    // Request addresses in flight toward the memory output
    prefetch_pkg::addr_t req_pipe [LAT];
    int                  cycle_count = 0;
    int                  cycle_limit = 0;

    // 100 ns period
    always #50 clk = ~clk;

    prefetch_top u_prefetch_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .base_addr   (base_addr),
        .length      (length),
        .mem_rd_en   (mem_rd_en),
        .mem_addr    (mem_addr),
        .mem_rd_data (mem_rd_data),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_ready   (out_ready),
        .busy        (busy),
        .done        (done),
        .oflow       (oflow)
    );

    prefetch_scoreboard u_scoreboard (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .mem_rd_en (mem_rd_en),
        .busy      (busy),
        .done      (done),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    bind prefetch_top prefetch_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rd_en (mem_rd_en),
        .buf_count (u_fifo.count),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .done      (done),
        .oflow     (oflow)
    );

    // --------------------------------------------------
    // Memory model
    // --------------------------------------------------
    // Memory contents follow the address, 3 * addr + 0x5A00
    function automatic prefetch_pkg::data_t mem_word(prefetch_pkg::addr_t addr);
        logic [31:0] full;
        full = 32'(addr) * 32'd3 + 32'h5a00;
        return full[`PF_DATA_WID-1:0];
    endfunction

    always @(posedge clk) begin
        req_pipe[0] <= mem_addr;
        for (int i = 1; i < LAT; i++) begin
            req_pipe[i] <= req_pipe[i-1];
        end
    end

    // Last stage holds the request from LAT cycles back
    always @(negedge clk) begin
        mem_rd_data <= mem_word(req_pipe[LAT-1]);
    end

    // Watchdog over the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run took more than %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    function automatic logic draw_ready(int stall_pct);
        return (($urandom % 100) >= stall_pct);
    endfunction

    task automatic read_trace(output bit opened);
        int    fd;
        int    fields;
        int    base;
        int    len;
        int    stall;
        string line;
        string name;
        fd = $fopen("tb/prefetch_trace.txt", "r");
        opened = (fd != 0);
        if (opened) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Comment lines start with #
                if (line.len() > 0 && line[0] != "#") begin
                    fields = $sscanf(line, "%s %h %d %d", name, base, len, stall);
                    if (fields == 4) begin
                        names.push_back(name);
                        bases.push_back(prefetch_pkg::addr_t'(base));
                        lengths.push_back(prefetch_pkg::len_t'(len));
                        stalls.push_back(stall);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_job(string name, prefetch_pkg::addr_t base,
                           prefetch_pkg::len_t len, int stall);
        int   n;
        logic done_seen;
        n = 0;
        done_seen = 1'b0;
        u_scoreboard.begin_test(name, base, len);
        start     = 1'b1;
        base_addr = base;
        length    = len;
        out_ready = draw_ready(stall);
        while (!done_seen) begin
            @(negedge clk);
            n++;
            done_seen = done;
            // Second start while busy, with other values, must be ignored
            start     = !done_seen && busy && (n == 3);
            base_addr = ~base;
            length    = len + 8'd7;
            out_ready = draw_ready(stall);
        end
        start = 1'b0;
        // Tail cycles catch a second done or a stray word
        repeat (2) begin
            @(negedge clk);
            out_ready = 1'b1;
        end
        u_scoreboard.finish_test();
    endtask

    initial begin
        int total_errors;
        bit opened;
        void'($urandom(32'hd9b9));
        rst_n     = 1'b0;
        start     = 1'b0;
        base_addr = '0;
        length    = '0;
        out_ready = 1'b0;
        read_trace(opened);
        if (!opened) begin
            $display("Could not open the trace file tb/prefetch_trace.txt");
            $display("Testbench failed");
        end else begin
            foreach (lengths[i]) begin
                cycle_limit = cycle_limit + int'(lengths[i]) * 4 + 50;
            end
            repeat (16) @(negedge clk);
            rst_n = 1'b1;
            // Idle window, outputs must stay low until the first start
            repeat (4) @(negedge clk);
            foreach (names[i]) begin
                run_job(names[i], bases[i], lengths[i], stalls[i]);
            end
            total_errors = u_scoreboard.error_count + u_prefetch_top.u_checker.fail_count;
            if (names.size() == 0) begin
                $display("The trace file holds no tests");
                total_errors++;
            end
            u_scoreboard.report_counts(u_prefetch_top.u_checker.fail_count);
            if (total_errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
        end
        $finish;
    end

endmodule : tb_prefetch_top

`default_nettype wire

/* tb/prefetch_scoreboard.sv */
// Predicts consumer words from the memory address rule; assumes one job at a time, set by begin_test
`default_nettype none
`timescale 1ns/100ps

`include "prefetch_defines.svh"

module prefetch_scoreboard (
    input logic                clk,
    input logic                rst_n,
    input logic                start,
    input logic                mem_rd_en,
    input logic                busy,
    input logic                done,
    input logic                out_valid,
    input logic                out_ready,
    input prefetch_pkg::data_t out_data
);

    int                  error_count  = 0;
    int                  tests_run    = 0;
    int                  tests_failed = 0;
    int                  test_errors  = 0;
    int                  done_count   = 0;
    int                  word_index   = 0;
    int                  words_left   = 0;
    string               test_name    = "none";
    prefetch_pkg::addr_t exp_addr     = '0;
    prefetch_pkg::len_t  test_len     = '0;
    logic                started      = 1'b0;
    logic                last_xfer    = 1'b0;
    logic                exp_busy     = 1'b0;
    logic                prev_last;

    // Same address rule as the memory holds
    function automatic prefetch_pkg::data_t expected_word(prefetch_pkg::addr_t addr);
        logic [31:0] full;
        full = 32'(addr) * 32'd3 + 32'h5a00;
        return full[`PF_DATA_WID-1:0];
    endfunction

    task automatic report_error(string msg);
        error_count++;
        test_errors++;
        $display("%s", msg);
    endtask

    // --------------------------------------------------
    // Test bookkeeping
    // --------------------------------------------------
    task automatic begin_test(string name, prefetch_pkg::addr_t base, prefetch_pkg::len_t len);
        test_name   = name;
        exp_addr    = base;
        test_len    = len;
        words_left  = int'(len);
        word_index  = 0;
        done_count  = 0;
        test_errors = 0;
        last_xfer   = 1'b0;
    endtask

    task automatic finish_test();
        if (words_left != 0) begin
            report_error($sformatf("Test %s: %0d words never arrived", test_name, words_left));
        end
        if (done_count != 1) begin
            report_error($sformatf("Test %s: expected one done pulse, saw %0d",
                                   test_name, done_count));
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s: %0d words", test_name, test_len);
        end else begin
            tests_failed++;
            $display("FAIL %s: %0d errors", test_name, test_errors);
        end
        words_left = 0;
    endtask

    task automatic report_counts(int assert_fails);
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count, assert_fails);
    endtask

    // --------------------------------------------------
    // Monitor, sampled at the rising edge
    // --------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            // Quiet outputs until the first start
            if (!started) begin
                if (start) begin
                    started = 1'b1;
                end else if (out_valid || mem_rd_en || busy || done) begin
                    report_error("Output active after reset before the first start");
                end
            end
            // busy spans the cycle after start up to the final transfer
            if (busy !== exp_busy) begin
                report_error($sformatf("MISMATCH test %s busy: expected %b, actual %b",
                                       test_name, exp_busy, busy));
            end
            if (start && !exp_busy && test_len != 0) begin
                exp_busy = 1'b1;
            end
            prev_last = last_xfer;
            last_xfer = 1'b0;
            if (out_valid && words_left == 0) begin
                report_error($sformatf("Test %s: out_valid high with no word expected",
                                       test_name));
            end else if (out_valid && out_ready) begin
                if (out_data !== expected_word(exp_addr)) begin
                    report_error($sformatf("MISMATCH test %s word %0d: expected %h, actual %h",
                                           test_name, word_index, expected_word(exp_addr),
                                           out_data));
                end
                exp_addr   = exp_addr + 1'b1;
                word_index++;
                words_left--;
                last_xfer  = (words_left == 0);
            end
            // Job leaves busy with its last word
            if (last_xfer) begin
                exp_busy = 1'b0;
            end
            // done belongs on the cycle after the final transfer
            if (done) begin
                done_count++;
                if (test_len != 0 && !prev_last) begin
                    report_error($sformatf("Test %s: done did not follow the last transfer",
                                           test_name));
                end
            end
        end
    end

endmodule : prefetch_scoreboard

`default_nettype wire

/* tb/prefetch_checker.sv */
// Protocol assertions bound into prefetch_top; all are off while rst_n is low
`default_nettype none
`timescale 1ns/100ps

`include "prefetch_defines.svh"

module prefetch_checker #(
    // Buffer depth, headroom for the in-flight words doubled to a power of two
    parameter int BUF_DEPTH = 2 ** $clog2(2 * (`PF_PIPELINE_DEPTH + 1))
) (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             mem_rd_en,
    input logic [$clog2(BUF_DEPTH + 1)-1:0] buf_count,
    input logic                             out_valid,
    input logic                             out_ready,
    input prefetch_pkg::data_t              out_data,
    input logic                             done,
    input logic                             oflow
);

    // Read by the testbench top at the end of the run
    int fail_count = 0;

    // --------------------------------------------------
    // Buffer protection
    // --------------------------------------------------
    // Headroom above the midpoint covers every word in flight
    no_oflow: assert property (@(posedge clk) disable iff (!rst_n) !oflow)
        else begin
            fail_count = fail_count + 1;
            $error("oflow went high, a write hit a full buffer");
        end

    // Requests stop once the buffer holds more than half its depth
    req_throttled: assert property (@(posedge clk) disable iff (!rst_n)
                                    mem_rd_en |-> buf_count <= BUF_DEPTH / 2)
        else begin
            fail_count = fail_count + 1;
            $error("mem_rd_en high while the buffer is past its midpoint");
        end

    // --------------------------------------------------
    // Host and consumer side
    // --------------------------------------------------
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            fail_count = fail_count + 1;
            $error("done stayed high for more than one cycle");
        end

    // Head word holds while the consumer stalls
    data_held: assert property (@(posedge clk) disable iff (!rst_n)
                                out_valid && !out_ready |=> $stable(out_data))
        else begin
            fail_count = fail_count + 1;
            $error("out_data changed while out_valid was high and out_ready low");
        end

endmodule : prefetch_checker

`default_nettype wire

/* logic/prefetch_top.sv */
// Prefetcher top level; one job at a time, memory must answer every read after PF_MEM_LATENCY cycles
`default_nettype none
`timescale 1ns/100ps

`include "prefetch_defines.svh"

module prefetch_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  prefetch_pkg::addr_t base_addr,
    input  prefetch_pkg::len_t  length,
    output logic                mem_rd_en,
    output prefetch_pkg::addr_t mem_addr,
    input  prefetch_pkg::data_t mem_rd_data,
    output logic                out_valid,
    output prefetch_pkg::data_t out_data,
    input  logic                out_ready,
    output logic                busy,
    output logic                done,
    output logic                oflow
);

    // Aligner to buffer write path
    prefetch_wr_if wr_if ();

    // --------------------------------------------------
    // Job controller
    // --------------------------------------------------
    prefetch_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .base_addr (base_addr),
        .length    (length),
        .wr_rdy    (wr_if.wr_rdy),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .mem_rd_en (mem_rd_en),
        .mem_addr  (mem_addr),
        .busy      (busy),
        .done      (done)
    );

    // Request strobe doubles as the return tag
    resp_align u_align (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (mem_rd_en),
        .mem_rd_data (mem_rd_data),
        .wr_port     (wr_if.producer)
    );

    // --------------------------------------------------
    // Prefetch buffer
    // --------------------------------------------------
    fifo_small_prefetch #(
        .PIPELINE_DEPTH (`PF_PIPELINE_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_port (wr_if.buffer),
        .rd      (out_ready),
        .rd_rdy  (out_valid),
        .rd_data (out_data)
    );

    // Watch output only
    assign oflow = wr_if.oflow;

endmodule : prefetch_top

`default_nettype wire

/* logic/resp_align.sv */
// Marks memory return cycles; assumes data comes exactly PF_MEM_LATENCY cycles after each request
`default_nettype none
`timescale 1ns/100ps

`include "prefetch_defines.svh"

module resp_align (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  prefetch_pkg::data_t mem_rd_data,
    prefetch_wr_if.producer     wr_port
);

    localparam int LAT = `PF_MEM_LATENCY;

    // One tag bit per cycle in flight
    logic [LAT-1:0] tag;

    // --------------------------------------------------
    // Tag pipeline
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag <= '0;
        end else begin
            tag[0] <= req;
            for (int i = 1; i < LAT; i++) begin
                tag[i] <= tag[i-1];
            end
        end
    end

    // Oldest tag lines up with the returning word
    assign wr_port.wr      = tag[LAT-1];
    assign wr_port.wr_data = mem_rd_data;

endmodule : resp_align

`default_nettype wire

/* logic/prefetch_ctrl.sv */
// Job controller for one job at a time; start while busy is ignored and addresses do not wrap
`default_nettype none
`timescale 1ns/100ps

module prefetch_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  prefetch_pkg::addr_t base_addr,
    input  prefetch_pkg::len_t  length,
    input  logic                wr_rdy,
    input  logic                out_valid,
    input  logic                out_ready,
    output logic                mem_rd_en,
    output prefetch_pkg::addr_t mem_addr,
    output logic                busy,
    output logic                done
);

    prefetch_pkg::ctrl_state_t state;
    prefetch_pkg::addr_t       next_addr;
    prefetch_pkg::len_t        req_left;
    prefetch_pkg::len_t        cons_left;
    logic                      xfer;

    // --------------------------------------------------
    // Request issue
    // --------------------------------------------------
    // One read per cycle while the buffer has headroom
    assign mem_rd_en = (state == prefetch_pkg::FETCH) && wr_rdy && (req_left != '0);
    assign mem_addr  = next_addr;
    assign busy      = (state != prefetch_pkg::IDLE);

    // Word taken by the consumer
    assign xfer = out_valid && out_ready;

    // --------------------------------------------------
    // Sequencing
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= prefetch_pkg::IDLE;
            next_addr <= '0;
            req_left  <= '0;
            cons_left <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            // Consumed words count down across FETCH and DRAIN
            if (busy && xfer) begin
                cons_left <= cons_left - 1'b1;
            end
            case (state)
                prefetch_pkg::IDLE: begin
                    if (start) begin
                        next_addr <= base_addr;
                        req_left  <= length;
                        cons_left <= length;
                        // Empty job finishes at once
                        if (length == '0) begin
                            done <= 1'b1;
                        end else begin
                            state <= prefetch_pkg::FETCH;
                        end
                    end
                end
                prefetch_pkg::FETCH: begin
                    if (mem_rd_en) begin
                        next_addr <= next_addr + 1'b1;
                        req_left  <= req_left - 1'b1;
                        if (req_left == 1) begin
                            state <= prefetch_pkg::DRAIN;
                        end
                    end
                end
                prefetch_pkg::DRAIN: begin
                    // Last word out ends the job
                    if (xfer && cons_left == 1) begin
                        state <= prefetch_pkg::IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= prefetch_pkg::IDLE;
            endcase
        end
    end

endmodule : prefetch_ctrl

`default_nettype wire

/* logic/fifo_small_prefetch.sv */
// Register prefetch buffer; a producer may still write PIPELINE_DEPTH words after wr_rdy falls
`default_nettype none
`timescale 1ns/100ps

`include "prefetch_defines.svh"

module fifo_small_prefetch #(
    parameter int PIPELINE_DEPTH = `PF_PIPELINE_DEPTH
) (
    input  logic                clk,
    input  logic                rst_n,
    prefetch_wr_if.buffer       wr_port,
    input  logic                rd,
    output logic                rd_rdy,
    output prefetch_pkg::data_t rd_data
);

    // --------------------------------------------------
    // Sizing
    // --------------------------------------------------
    // Headroom above the midpoint covers the in-flight writes
    localparam int PTR_WID = $clog2(2 * (PIPELINE_DEPTH + 1));
    localparam int DEPTH   = 2**PTR_WID;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    prefetch_pkg::data_t mem [DEPTH];

    logic               wr_safe;
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;

    fifo_ctrl_fsm #(
        .DEPTH (DEPTH)
    ) u_fifo_ctrl_fsm (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr_port.wr),
        .rd      (rd),
        .wr_safe (wr_safe),
        .wr_ptr  (wr_ptr),
        .rd_ptr  (rd_ptr),
        .count   (count),
        .oflow   (wr_port.oflow)
    );

    // Request side stops once past the midpoint
    assign wr_port.wr_rdy = (count <= CNT_WID'(DEPTH / 2));

    // Storage, no reset on the words
    always_ff @(posedge clk) begin
        if (wr_safe) begin
            mem[wr_ptr] <= wr_port.wr_data;
        end
    end

    // Head word shown without a register stage
    assign rd_data = mem[rd_ptr];
    assign rd_rdy  = (count != '0);

endmodule : fifo_small_prefetch

`default_nettype wire

/* logic/fifo_ctrl_fsm.sv */
// Single-clock FIFO pointer control; DEPTH must be a power of two, full blocks writes, empty blocks reads
`default_nettype none
`timescale 1ns/100ps

module fifo_ctrl_fsm #(
    parameter int DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr,
    input  logic                       rd,
    output logic                       wr_safe,
    output logic [$clog2(DEPTH)-1:0]   wr_ptr,
    output logic [$clog2(DEPTH)-1:0]   rd_ptr,
    output logic [$clog2(DEPTH+1)-1:0] count,
    output logic                       oflow
);

    localparam int PTR_WID = $clog2(DEPTH);
    localparam int CNT_WID = $clog2(DEPTH + 1);

    logic full;
    logic empty;
    logic rd_safe;

    // --------------------------------------------------
    // Protection
    // --------------------------------------------------
    assign full  = (count == CNT_WID'(DEPTH));
    assign empty = (count == '0);

    // Write dropped when full, even with a read in the same cycle
    assign wr_safe = wr && !full;
    // Read of an empty buffer is ignored
    assign rd_safe = rd && !empty;

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            oflow  <= 1'b0;
        end else begin
            // Pointers wrap by overflow of the power of two
            if (wr_safe) begin
                wr_ptr <= wr_ptr + PTR_WID'(1);
            end
            if (rd_safe) begin
                rd_ptr <= rd_ptr + PTR_WID'(1);
            end
            // Count moves only on an unpaired write or read
            case ({wr_safe, rd_safe})
                2'b10:   count <= count + CNT_WID'(1);
                2'b01:   count <= count - CNT_WID'(1);
                default: count <= count;
            endcase
            // Sticky until reset, for monitoring
            if (wr && full) begin
                oflow <= 1'b1;
            end
        end
    end

endmodule : fifo_ctrl_fsm

`default_nettype wire

/* logic/prefetch_wr_if.sv */
// Buffer write side; wr is taken every cycle it is high, and wr_rdy only advises the request side
`default_nettype none
`timescale 1ns/100ps

interface prefetch_wr_if;

    // Write strobe, one word per cycle
    logic                wr;
    // Word written with the strobe
    prefetch_pkg::data_t wr_data;
    // Buffer at or below its midpoint
    logic                wr_rdy;
    // Sticky, a write hit a full buffer
    logic                oflow;

    // Response side pushes words
    // wr_rdy is visible here so a producer could throttle itself
    modport producer (
        output wr,
        output wr_data,
        input  wr_rdy
    );

    // Prefetch buffer side
    modport buffer (
        input  wr,
        input  wr_data,
        output wr_rdy,
        output oflow
    );

endinterface : prefetch_wr_if

`default_nettype wire

/* logic/prefetch_pkg.sv */
// Types for the prefetcher; widths follow prefetch_defines.svh and nothing here holds state
`default_nettype none

`include "prefetch_defines.svh"

package prefetch_pkg;

    // --------------------------------------------------
    // Datapath vectors
    // --------------------------------------------------
    // One memory word as returned by the memory
    typedef logic [`PF_DATA_WID-1:0] data_t;

    // Word address on the memory side
    typedef logic [`PF_ADDR_WID-1:0] addr_t;

    // Words per job, also used for the countdowns
    typedef logic [`PF_LEN_WID-1:0]  len_t;

    // --------------------------------------------------
    // Job controller FSM
    // --------------------------------------------------
    // IDLE waits for start
    // FETCH issues reads while the buffer has headroom
    // DRAIN waits for the consumer to take the last words
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DRAIN
    } ctrl_state_t;

endpackage : prefetch_pkg

`default_nettype wire

/* include/prefetch_defines.svh */
// Shared widths and timing; PF_PIPELINE_DEPTH must not be below PF_MEM_LATENCY or the buffer can overflow
`ifndef PREFETCH_DEFINES_SVH
`define PREFETCH_DEFINES_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
// One memory word
`define PF_DATA_WID 16
// Memory address, no wrap handling at the top
`define PF_ADDR_WID 12
// Job word count, zero is a legal empty job
`define PF_LEN_WID 8

// --------------------------------------------------
// Timing
// --------------------------------------------------
// Fixed cycles from read request to read data
`define PF_MEM_LATENCY 3
// Writes the buffer absorbs after write-ready falls
`define PF_PIPELINE_DEPTH `PF_MEM_LATENCY

`endif
